// ==== Bender.yml ====
package:
  name: dma_subsystem

sources:
  - dma_pkg.sv
  - byte_fifo.sv
  - word_memory.sv
  - memory_dma.sv
  - dma_subsystem.sv
  - target: test
    files:
      - tb_dma_subsystem.sv

// ==== byte_fifo.sv ====
`timescale 1ns/100ps

module byte_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic               clk,
    input  logic               reset,
    input  logic               write,
    input  dma_pkg::dma_byte_t wdata,
    input  logic               read,
    output dma_pkg::dma_byte_t rdata,
    output logic               empty,
    output logic               full
);
    import dma_pkg::*;

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_W = $clog2(FIFO_DEPTH + 1);

    dma_byte_t        buffer [FIFO_DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_write;
    logic             do_read;

    assign empty    = (count == '0);
    assign full     = (count == CNT_W'(FIFO_DEPTH));
    assign do_write = write && !full;    // Dropped when full
    assign do_read  = read && !empty;

    always_ff @(posedge clk) begin
        if (do_write) begin
            buffer[wr_ptr] <= wdata;
        end
        if (do_read) begin
            rdata <= buffer[rd_ptr];     // Data follows read by one cycle
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_write) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (do_read) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

// ==== dma_pkg.sv ====
package dma_pkg;

    // Byte address into the word memory
    typedef logic [26:0] dma_addr_t;

    // Transfer length in bytes
    typedef logic [26:0] dma_len_t;

    typedef logic [7:0]  dma_byte_t;

    // Even-address byte sits in the high half
    typedef logic [15:0] dma_word_t;

    // Bit 1 enables the even-address byte
    typedef logic [1:0]  dma_mask_t;

    // Transfer command
    typedef struct packed {
        logic      start;
        logic      stop;
        logic      direction;        // Set for FIFO to memory
        logic      byte_swap;        // Receive path only
        dma_addr_t starting_address;
        dma_len_t  transfer_length;
    } dma_cmd_t;

    // Memory request, held stable until ack
    typedef struct packed {
        logic      request;
        logic      write;
        dma_addr_t address;
        dma_mask_t wmask;
        dma_word_t wdata;
    } mem_req_t;

    // Memory response
    typedef struct packed {
        logic      ack;     // Single-cycle pulse
        dma_word_t rdata;   // Valid with ack on reads
    } mem_rsp_t;

endpackage

// ==== dma_subsystem.sv ====
`timescale 1ns/100ps

module dma_subsystem #(
    parameter int FIFO_DEPTH  = 8,
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = 2
) (
    input  logic               clk,
    input  logic               reset,
    input  dma_pkg::dma_cmd_t  cmd,
    output logic               busy,
    input  logic               rx_push,
    input  dma_pkg::dma_byte_t rx_byte,
    output logic               rx_full,
    input  logic               tx_pop,
    output dma_pkg::dma_byte_t tx_byte,
    output logic               tx_empty
);
    import dma_pkg::*;

    // Receive FIFO to engine
    logic      rx_read;
    dma_byte_t rx_rdata;
    logic      rx_empty;

    // Engine to transmit FIFO
    logic      tx_write;
    dma_byte_t tx_wdata;
    logic      tx_full;

    mem_req_t  mem_req;
    mem_rsp_t  mem_rsp;

    byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) rx_fifo_i (
        .clk   (clk),
        .reset (reset),
        .write (rx_push),
        .wdata (rx_byte),
        .read  (rx_read),
        .rdata (rx_rdata),
        .empty (rx_empty),
        .full  (rx_full)
    );

    memory_dma memory_dma_i (
        .clk      (clk),
        .reset    (reset),
        .cmd      (cmd),
        .busy     (busy),
        .rx_rdata (rx_rdata),
        .rx_empty (rx_empty),
        .rx_read  (rx_read),
        .tx_write (tx_write),
        .tx_wdata (tx_wdata),
        .tx_full  (tx_full),
        .req      (mem_req),
        .rsp      (mem_rsp)
    );

    word_memory #(
        .MEM_WORDS   (MEM_WORDS),
        .MEM_LATENCY (MEM_LATENCY)
    ) word_memory_i (
        .clk   (clk),
        .reset (reset),
        .req   (mem_req),
        .rsp   (mem_rsp)
    );

    byte_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) tx_fifo_i (
        .clk   (clk),
        .reset (reset),
        .write (tx_write),
        .wdata (tx_wdata),
        .read  (tx_pop),
        .rdata (tx_byte),
        .empty (tx_empty),
        .full  (tx_full)
    );

endmodule

// ==== memory_dma.sv ====
`timescale 1ns/100ps

module memory_dma (
    input  logic               clk,
    input  logic               reset,
    input  dma_pkg::dma_cmd_t  cmd,
    output logic               busy,
    input  dma_pkg::dma_byte_t rx_rdata,
    input  logic               rx_empty,
    output logic               rx_read,
    output logic               tx_write,
    output dma_pkg::dma_byte_t tx_wdata,
    input  logic               tx_full,
    output dma_pkg::mem_req_t  req,
    input  dma_pkg::mem_rsp_t  rsp
);
    import dma_pkg::*;

    logic       cmd_start;
    logic       swap_q;
    logic       odd_start_q;
    dma_len_t   remaining;
    logic       active;

    // Memory request registers
    logic       req_request;
    logic       req_write;      // Also the direction of the transfer
    dma_addr_t  req_address;
    dma_mask_t  req_wmask;
    dma_word_t  req_wdata;

    // Receive packing
    dma_word_t  rx_buf;
    dma_mask_t  rx_lanes;       // Halves of rx_buf holding real bytes
    logic [1:0] rx_cnt;         // Shifts done into rx_buf
    logic       rx_valid;       // rx_rdata lands this cycle
    logic       rx_room;
    logic       rx_pad;
    logic       rx_shift;
    logic       rx_issue;

    // Transmit unpacking
    dma_word_t  tx_buf;
    logic [1:0] tx_cnt;         // Bytes left in tx_buf
    logic       tx_first;
    logic       tx_issue;

    assign cmd_start = cmd.start && !cmd.stop && !busy;
    assign active    = (remaining != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            swap_q      <= 1'b0;
            odd_start_q <= 1'b0;
        end else if (cmd_start) begin
            swap_q      <= cmd.byte_swap;
            odd_start_q <= cmd.starting_address[0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset || cmd.stop) begin
            remaining <= '0;
        end else if (cmd_start) begin
            remaining <= cmd.transfer_length;
        end else if (rx_read || tx_write) begin
            remaining <= remaining - 1'b1;
        end
    end

    // Receive direction

    // At most two bytes claimed, counting one in flight
    assign rx_room  = (rx_cnt == 2'd0) || (rx_cnt == 2'd1 && !rx_valid);
    assign rx_read  = req_write && active && !rx_empty && rx_room && !cmd.stop;
    // Odd end: push the last byte up into the high half
    assign rx_pad   = req_write && rx_cnt == 2'd1 && !active && !rx_valid;
    assign rx_shift = rx_valid || rx_pad;
    assign rx_issue = req_write && rx_cnt == 2'd2 && !req_request;

    always_ff @(posedge clk) begin
        if (rx_shift) begin
            if (swap_q) begin
                rx_buf <= {rx_rdata, rx_buf[15:8]};
            end else begin
                rx_buf <= {rx_buf[7:0], rx_rdata};
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            rx_valid <= 1'b0;
            rx_cnt   <= 2'd0;
            rx_lanes <= 2'b00;
        end else begin
            rx_valid <= rx_read;
            if (cmd.stop || rx_issue) begin
                rx_cnt   <= 2'd0;
                rx_lanes <= 2'b00;
            end else if (cmd_start) begin
                // Odd start leaves an empty slot before the first byte
                rx_cnt   <= {1'b0, cmd.direction && cmd.starting_address[0] &&
                                   cmd.transfer_length != '0};
                rx_lanes <= 2'b00;
            end else if (rx_shift) begin
                rx_cnt   <= rx_cnt + 2'd1;
                rx_lanes <= swap_q ? {rx_valid, rx_lanes[1]} : {rx_lanes[0], rx_valid};
            end
        end
    end

    // Transmit direction

    assign tx_issue = !req_write && active && tx_cnt == 2'd0 && !req_request;
    assign tx_write = !req_write && active && tx_cnt != 2'd0 && !tx_full && !cmd.stop;
    assign tx_wdata = tx_cnt[1] ? tx_buf[15:8] : tx_buf[7:0];    // High byte first

    always_ff @(posedge clk) begin
        if (rsp.ack && !req_write) begin
            tx_buf <= rsp.rdata;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            tx_cnt   <= 2'd0;
            tx_first <= 1'b0;
        end else begin
            if (cmd.stop || cmd_start) begin
                tx_cnt   <= 2'd0;
                tx_first <= cmd_start;
            end else if (rsp.ack && !req_write) begin
                // Skip the even byte of the first word on an odd start
                tx_cnt   <= (tx_first && odd_start_q) ? 2'd1 : 2'd2;
                tx_first <= 1'b0;
            end else if (tx_write) begin
                tx_cnt <= tx_cnt - 2'd1;
            end
        end
    end

    // Memory request

    always_ff @(posedge clk) begin
        if (reset) begin
            req_request <= 1'b0;
            req_write   <= 1'b0;
        end else begin
            if (cmd_start) begin
                req_write <= cmd.direction;
            end
            if (rsp.ack) begin
                req_request <= 1'b0;
            end else if (rx_issue || tx_issue) begin
                req_request <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (cmd_start) begin
            req_address <= {cmd.starting_address[26:1], 1'b0};
        end else if (rsp.ack) begin
            req_address <= req_address + dma_addr_t'(2);
        end
        if (rx_issue) begin
            req_wmask <= rx_lanes;
            req_wdata <= rx_buf;
        end
    end

    assign req = '{
        request: req_request,
        write:   req_write,
        address: req_address,
        wmask:   req_wmask,
        wdata:   req_wdata
    };

    // Holds through the last write until its ack
    always_ff @(posedge clk) begin
        if (reset) begin
            busy <= 1'b0;
        end else begin
            busy <= cmd_start || active || req_request || rx_cnt != 2'd0 || rx_valid;
        end
    end

endmodule

// ==== tb.f ====
dma_pkg.sv
byte_fifo.sv
word_memory.sv
memory_dma.sv
dma_subsystem.sv
tb_dma_subsystem.sv

// ==== tb_dma_subsystem.sv ====
`timescale 1ns/100ps

module tb_dma_subsystem;
    import dma_pkg::*;

    localparam int TIMEOUT     = 2000;   // Cycles allowed per wait
    localparam int MODEL_BYTES = 512;    // MEM_WORDS * 2

    logic      clk;
    logic      reset;
    dma_cmd_t  cmd;
    logic      busy;
    logic      rx_push;
    dma_byte_t rx_byte;
    logic      rx_full;
    logic      tx_pop;
    dma_byte_t tx_byte;
    logic      tx_empty;

    dma_byte_t   model_mem [MODEL_BYTES];   // Expected memory contents by byte address
    logic [31:0] rng_state = 32'd16826;
    int          test_errors  = 0;
    int          total_errors = 0;
    int          tests_run    = 0;
    int          tests_failed = 0;

    dma_subsystem dut_i (
        .clk      (clk),
        .reset    (reset),
        .cmd      (cmd),
        .busy     (busy),
        .rx_push  (rx_push),
        .rx_byte  (rx_byte),
        .rx_full  (rx_full),
        .tx_pop   (tx_pop),
        .tx_byte  (tx_byte),
        .tx_empty (tx_empty)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic dma_byte_t next_random();
        rng_state ^= rng_state << 13;
        rng_state ^= rng_state >> 17;
        rng_state ^= rng_state << 5;
        return rng_state[7:0];
    endfunction

    task automatic compare_byte(input string name, input dma_byte_t got, input dma_byte_t exp);
        if (got !== exp) begin
            $display("FAIL at %0t: %s got %h expected %h", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL at %0t: %s got %b expected %b", $time, name, got, exp);
            test_errors++;
        end
    endtask

    task automatic abort_run(input string what);
        $display("Timed out at %0t while waiting for %s", $time, what);
        $display("Simulation finished: FAIL");
        $finish;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (test_errors == 0) begin
            $display("%s: ok", name);
        end else begin
            $display("%s: %0d errors", name, test_errors);
            tests_failed++;
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    task automatic wait_idle();
        int n;
        n = 0;
        while (busy) begin
            if (n == TIMEOUT) abort_run("busy to fall");
            @(negedge clk);
            n++;
        end
    endtask

    // All tasks start and end just after a falling edge
    task automatic start_command(input logic dir, input logic swap, input dma_addr_t addr,
                                 input dma_len_t len);
        cmd.start            = 1'b1;
        cmd.stop             = 1'b0;
        cmd.direction        = dir;
        cmd.byte_swap        = swap;
        cmd.starting_address = addr;
        cmd.transfer_length  = len;
        @(negedge clk);
        cmd.start = 1'b0;
        compare_flag("busy after start", busy, 1'b1);
    endtask

    task automatic push_byte(input dma_byte_t b);
        int n;
        n = 0;
        while (rx_full) begin
            if (n == TIMEOUT) abort_run("rx_full to clear");
            @(negedge clk);
            n++;
        end
        rx_push = 1'b1;
        rx_byte = b;
        @(negedge clk);
        rx_push = 1'b0;
    endtask

    task automatic pop_byte(output dma_byte_t b);
        int n;
        n = 0;
        while (tx_empty) begin
            if (n == TIMEOUT) abort_run("a byte in the transmit FIFO");
            @(negedge clk);
            n++;
        end
        tx_pop = 1'b1;
        @(negedge clk);
        tx_pop = 1'b0;
        b = tx_byte;     // Registered at the pop edge
    endtask

    // Swap exchanges the bytes within each word, even start only
    task automatic write_block(input int addr, input int len, input logic swap);
        dma_byte_t b;
        start_command(1'b1, swap, addr, len);
        for (int i = 0; i < len; i++) begin
            b = next_random();
            model_mem[((addr + i) ^ int'(swap)) % MODEL_BYTES] = b;
            push_byte(b);
        end
        wait_idle();
    endtask

    task automatic pop_and_check(input int addr, input int len);
        dma_byte_t b;
        for (int i = 0; i < len; i++) begin
            pop_byte(b);
            compare_byte($sformatf("tx_byte @%0d", addr + i), b,
                         model_mem[(addr + i) % MODEL_BYTES]);
        end
    endtask

    task automatic read_block(input int addr, input int len);
        start_command(1'b0, 1'b0, addr, len);
        pop_and_check(addr, len);
        wait_idle();
    endtask

    task automatic test_reset_state();
        compare_flag("busy", busy, 1'b0);
        compare_flag("tx_empty", tx_empty, 1'b1);
        compare_flag("rx_full", rx_full, 1'b0);
        finish_test("reset state");
    endtask

    task automatic test_round_trip();
        write_block(0, 16, 1'b0);
        read_block(0, 16);
        finish_test("even round trip");
    endtask

    task automatic test_odd_address();
        write_block(32, 10, 1'b0);    // Neighbors at 32 and 40
        write_block(33, 7, 1'b0);
        read_block(33, 7);
        read_block(32, 1);
        read_block(40, 1);
        write_block(48, 4, 1'b0);     // Neighbor at 51
        write_block(48, 3, 1'b0);     // Last word high only
        read_block(48, 3);
        read_block(51, 1);
        finish_test("odd address and length");
    endtask

    task automatic test_byte_swap();
        write_block(64, 8, 1'b1);
        read_block(64, 8);
        finish_test("byte swap");
    endtask

    task automatic test_tx_backpressure();
        int n;
        write_block(128, 20, 1'b0);
        start_command(1'b0, 1'b0, 128, 20);
        n = 0;
        while (!dut_i.tx_full) begin
            if (n == TIMEOUT) abort_run("the transmit FIFO to fill");
            @(negedge clk);
            n++;
        end
        compare_flag("busy while stalled", busy, 1'b1);
        pop_and_check(128, 20);
        wait_idle();
        compare_flag("tx_empty", tx_empty, 1'b1);
        finish_test("transmit back-pressure");
    endtask

    task automatic test_stop();
        dma_byte_t b;
        int        n;
        start_command(1'b0, 1'b0, 0, 32);
        pop_and_check(0, 3);
        cmd.stop = 1'b1;
        @(negedge clk);
        cmd.stop = 1'b0;
        wait_idle();
        n = 0;
        while (!tx_empty) begin   // Drop what was fetched before the stop
            if (n == TIMEOUT) abort_run("the transmit FIFO to drain");
            pop_byte(b);
            n++;
        end
        write_block(200, 10, 1'b0);
        read_block(200, 10);
        finish_test("stop");
    endtask

    initial begin
        reset   = 1'b1;
        cmd     = '0;
        rx_push = 1'b0;
        rx_byte = '0;
        tx_pop  = 1'b0;
        repeat (4) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        test_reset_state();
        test_round_trip();
        test_odd_address();
        test_byte_swap();
        test_tx_backpressure();
        test_stop();

        $display("%0d tests run, %0d failed, %0d check errors",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== word_memory.sv ====
`timescale 1ns/100ps

module word_memory #(
    parameter int MEM_WORDS   = 256,
    parameter int MEM_LATENCY = 2
) (
    input  logic              clk,
    input  logic              reset,
    input  dma_pkg::mem_req_t req,
    output dma_pkg::mem_rsp_t rsp
);
    import dma_pkg::*;

    localparam int IDX_W = (MEM_WORDS > 1) ? $clog2(MEM_WORDS) : 1;
    localparam int CNT_W = $clog2(MEM_LATENCY + 1);

    dma_word_t        mem [MEM_WORDS];
    logic [IDX_W-1:0] idx;
    logic [CNT_W-1:0] cnt;
    logic             active;
    logic             start_req;
    logic             fire;
    logic             ack_q;
    dma_word_t        rdata_q;

    // Word index wraps at MEM_WORDS
    assign idx = IDX_W'(req.address[26:1] % MEM_WORDS);

    // No new request while the ack is still out
    assign start_req = req.request && !active && !ack_q;
    assign fire = (MEM_LATENCY <= 1) ? start_req
                                     : (active && cnt == CNT_W'(MEM_LATENCY - 1));

    always_ff @(posedge clk) begin
        if (reset) begin
            active <= 1'b0;
            cnt    <= '0;
            ack_q  <= 1'b0;
        end else begin
            ack_q <= fire;
            if (fire) begin
                active <= 1'b0;
                cnt    <= '0;
            end else if (start_req) begin
                active <= 1'b1;
                cnt    <= CNT_W'(1);
            end else if (active) begin
                cnt <= cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            rdata_q <= mem[idx];
        end
        if (ack_q && req.request && req.write) begin
            if (req.wmask[1]) mem[idx][15:8] <= req.wdata[15:8];
            if (req.wmask[0]) mem[idx][7:0]  <= req.wdata[7:0];
        end
    end

    assign rsp = '{ack: ack_q, rdata: rdata_q};

endmodule
